/* rtl/softmax_macros.svh */
// softmax macros: datapath widths, lane count and fixed-point constants for the Q15.16 engine
`ifndef SOFTMAX_MACROS_SVH
`define SOFTMAX_MACROS_SVH

// full datapath word, sign included
`define SOFTMAX_WIDTH 32

// fraction bits of every Q15.16 value
`define SOFTMAX_FRAC 16

// vector length handled per start pulse
`define SOFTMAX_LANES 4

// log2(e) = 1.4426950 scaled by 2^16
`define SOFTMAX_LOG2E 32'sd94548

// ln(2) = 0.6931472 scaled by 2^16
`define SOFTMAX_LN2 32'sd45426

`endif

/* rtl/fixed_pkg.sv */
// fixed_pkg: number formats used across the Q15.16 softmax datapath
`include "softmax_macros.svh"

package fixed_pkg;

    // signed Q15.16 lane value, also used on the top-level ports
    typedef logic signed [`SOFTMAX_WIDTH-1:0] fx_t;

    // full product of two Q15.16 values, Q31.32
    // holds x*log2(e) in exp_unit and log2(x)*ln(2) in ln_unit
    typedef logic signed [2*`SOFTMAX_WIDTH-1:0] fx_wide_t;

endpackage

/* rtl/softmax_pkg.sv */
// softmax_pkg: structural types shared by the stages and the controller
`include "softmax_macros.svh"

package softmax_pkg;

    // one Q15.16 value per lane, lane 0 carries x1 / y1
    typedef fixed_pkg::fx_t lane_vec_t [`SOFTMAX_LANES];

    // start/busy controller
    // IDLE accepts a start, BUSY waits for the last stage
    typedef enum logic {
        IDLE = 1'b0,
        BUSY = 1'b1
    } ctrl_state_t;

endpackage

/* rtl/lane_vec_if.sv */
// lane_vec_if: carries one lane vector and its valid pulse from one stage to the next
`timescale 1ns/1ps

interface lane_vec_if;
    import softmax_pkg::*;

    // payload, held until the next valid pulse
    lane_vec_t lanes;
    // single-cycle pulse, one item in flight so no ready
    logic valid;

    // producing stage
    modport src (
        output lanes,
        output valid
    );

    // consuming stage
    modport dst (
        input lanes,
        input valid
    );

endinterface

/* rtl/exp_unit.sv */
// exp_unit: combinational e^x for non-positive Q15.16 input via base-2 range reduction
`timescale 1ns/1ps
`include "softmax_macros.svh"

module exp_unit (
    input  fixed_pkg::fx_t x,
    output fixed_pkg::fx_t y
);
    import fixed_pkg::*;

    localparam int W = `SOFTMAX_WIDTH;
    localparam int F = `SOFTMAX_FRAC;
    // 2^f ~ 1 + f*(c1 + c2*f), coefficients in Q0.16
    localparam logic [31:0] C1 = 32'd43024;
    localparam logic [31:0] C2 = 32'd22512;
    localparam logic [31:0] ONE = 32'd1 << F;
    // below -16 the result is under one lsb
    localparam fx_t X_MIN = -fx_t'(16 * (1 << F));

    fx_t          x_c;
    fx_wide_t     t;
    fx_t          k;
    fx_t          neg_k;
    logic [F-1:0] f;
    logic [31:0]  c2f;
    logic [31:0]  inner;
    logic [47:0]  fp;
    logic [31:0]  p;

    always_comb begin
        // positive arguments are clamped to 0, giving exactly 1.0
        if (x[W-1]) begin
            x_c = x;
        end else begin
            x_c = '0;
        end

        // t = x*log2(e) in Q.32, so e^x = 2^t
        t = fx_wide_t'(x_c) * fx_wide_t'(`SOFTMAX_LOG2E);
        // arithmetic slice gives floor, so k <= 0 and f in [0, 1)
        k = t[2*F+W-1:2*F];
        f = t[2*F-1:F];
        neg_k = -k;

        // polynomial for 2^f, inner term first
        c2f = ({16'd0, f} * C2) >> F;
        inner = C1 + c2f;
        fp = {32'd0, f} * {16'd0, inner};
        // p in [1, 2) as Q16
        p = ONE + fp[F+31:F];

        // 2^k scaling is a plain right shift since k <= 0
        if (x_c < X_MIN) begin
            y = '0;
        end else begin
            y = fx_t'(p >> neg_k[4:0]);
        end
    end

endmodule

/* rtl/ln_unit.sv */
// ln_unit gives the natural log of a positive Q15.16 value by leading-one detection
`timescale 1ns/1ps
`include "softmax_macros.svh"

module ln_unit (
    input  fixed_pkg::fx_t x,
    output fixed_pkg::fx_t y
);
    import fixed_pkg::*;

    localparam int W = `SOFTMAX_WIDTH;
    localparam int F = `SOFTMAX_FRAC;
    // log2(m) ~ u + c*u*(1-u) with u = m-1 and c = 0.3431 in Q0.16
    localparam logic [31:0] C_LN = 32'd22486;
    localparam logic [47:0] ONE = 48'd1 << F;
    // result for x <= 0
    localparam fx_t FX_MIN = {1'b1, {(W-1){1'b0}}};

    logic [W-1:0] xu;
    logic [4:0]   pos;
    logic [W-1:0] m;
    logic [F-1:0] u;
    logic [47:0]  uu;
    logic [47:0]  corr;
    fx_t          log2_x;
    fx_wide_t     prod;

    always_comb begin
        xu = x;
        pos = '0;
        // the highest set bit wins the leading-one search
        for (int i = 0; i < W; i++) begin
            if (xu[i]) begin
                pos = 5'(i);
            end
        end

        // normalize so the leading one sits at bit F and m lies in [1, 2)
        if (int'(pos) >= F) begin
            m = xu >> (int'(pos) - F);
        end else begin
            m = xu << (F - int'(pos));
        end
        u = m[F-1:0];

        // u*(1-u) in Q16 scaled by the correction constant
        uu = ({32'd0, u} * (ONE - {32'd0, u})) >> F;
        corr = uu * {16'd0, C_LN};

        // integer part of log2 is pos - F
        log2_x = fx_t'((int'(pos) - F) <<< F) + fx_t'(u) + fx_t'(corr[F+31:F]);

        // ln(x) = log2(x) * ln(2)
        prod = fx_wide_t'(log2_x) * fx_wide_t'(`SOFTMAX_LN2);

        if (x[W-1] || (x == '0)) begin
            y = FX_MIN;
        end else begin
            y = prod[F+W-1:F];
        end
    end

endmodule

/* rtl/max_normalize.sv */
// max_normalize: captures the input vector and subtracts the lane maximum from every lane
`timescale 1ns/1ps
`include "softmax_macros.svh"

module max_normalize (
    input logic        clk,
    input logic        rst_n,
    lane_vec_if.dst    in_vec,
    lane_vec_if.src    out_vec
);
    import fixed_pkg::*;
    import softmax_pkg::*;

    fx_t       max_01;
    fx_t       max_23;
    fx_t       max_all;
    lane_vec_t diff;

    // two-level compare tree over the signed lanes
    always_comb begin
        if (in_vec.lanes[0] > in_vec.lanes[1]) begin
            max_01 = in_vec.lanes[0];
        end else begin
            max_01 = in_vec.lanes[1];
        end

        if (in_vec.lanes[2] > in_vec.lanes[3]) begin
            max_23 = in_vec.lanes[2];
        end else begin
            max_23 = in_vec.lanes[3];
        end

        if (max_01 > max_23) begin
            max_all = max_01;
        end else begin
            max_all = max_23;
        end

        // every lane ends up zero or below, the max lane exactly zero
        for (int i = 0; i < `SOFTMAX_LANES; i++) begin
            diff[i] = in_vec.lanes[i] - max_all;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_vec.valid <= 1'b0;
        end else begin
            out_vec.valid <= in_vec.valid;
        end
    end

    // payload only moves with a valid item
    always_ff @(posedge clk) begin
        if (in_vec.valid) begin
            out_vec.lanes <= diff;
        end
    end

endmodule

/* rtl/exp_bank.sv */
// exp_bank registers four exponential lanes and the sum of their outputs
`timescale 1ns/1ps
`include "softmax_macros.svh"

module exp_bank (
    input  logic           clk,
    input  logic           rst_n,
    lane_vec_if.dst        in_vec,
    lane_vec_if.src        out_vec,
    output fixed_pkg::fx_t sum
);
    import fixed_pkg::*;
    import softmax_pkg::*;

    lane_vec_t exp_y;
    fx_t       sum_c;

    // one exponential per lane
    for (genvar i = 0; i < `SOFTMAX_LANES; i++) begin : g_lane
        exp_unit exp_unit_i (
            .x (in_vec.lanes[i]),
            .y (exp_y[i])
        );
    end

    // each term is at most 1.0 so four of them never overflow
    always_comb begin
        sum_c = '0;
        for (int i = 0; i < `SOFTMAX_LANES; i++) begin
            sum_c = sum_c + exp_y[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_vec.valid <= 1'b0;
        end else begin
            out_vec.valid <= in_vec.valid;
        end
    end

    // lanes and sum start from zero and load on a valid item
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_vec.lanes <= '{default: '0};
            sum <= '0;
        end else if (in_vec.valid) begin
            out_vec.lanes <= exp_y;
            sum <= sum_c;
        end
    end

endmodule

/* rtl/log_normalize.sv */
// log_normalize: subtracts ln of the exponential sum from every max-normalized lane
`timescale 1ns/1ps
`include "softmax_macros.svh"

module log_normalize (
    input logic           clk,
    input logic           rst_n,
    lane_vec_if.dst       norm_vec,
    lane_vec_if.dst       sum_vec,
    input fixed_pkg::fx_t sum,
    lane_vec_if.src       out_vec
);
    import fixed_pkg::*;
    import softmax_pkg::*;

    fx_t       ln_sum;
    lane_vec_t diff;

    // sum >= 1.0, so ln_sum >= 0
    ln_unit ln_unit_i (
        .x (sum),
        .y (ln_sum)
    );

    // norm_vec still holds the item, no new start is taken while busy
    always_comb begin
        for (int i = 0; i < `SOFTMAX_LANES; i++) begin
            diff[i] = norm_vec.lanes[i] - ln_sum;
        end
    end

    // sum_vec only supplies the timing, its lanes belong to exp_bank
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_vec.valid <= 1'b0;
        end else begin
            out_vec.valid <= sum_vec.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sum_vec.valid) begin
            out_vec.lanes <= diff;
        end
    end

endmodule

/* rtl/softmax_top.sv */
// softmax_top: four-lane log-domain softmax with start/busy control and a four-stage chain
`timescale 1ns/1ps

module softmax_top (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    input  fixed_pkg::fx_t x1,
    input  fixed_pkg::fx_t x2,
    input  fixed_pkg::fx_t x3,
    input  fixed_pkg::fx_t x4,
    output fixed_pkg::fx_t y1,
    output fixed_pkg::fx_t y2,
    output fixed_pkg::fx_t y3,
    output fixed_pkg::fx_t y4,
    output logic           busy,
    output logic           done
);
    import fixed_pkg::*;
    import softmax_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    // exp sum from the first bank, read by log_normalize
    fx_t         sum_a;

    // stage links
    lane_vec_if in_vec ();
    lane_vec_if norm_vec ();
    lane_vec_if exp_vec ();
    lane_vec_if log_vec ();
    lane_vec_if res_vec ();

    // controller
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_next = BUSY;
                end
            end
            BUSY: begin
                // last stage loads on this edge, done follows
                if (log_vec.valid) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // start while busy is dropped here
    assign in_vec.valid = start && (state == IDLE);
    assign in_vec.lanes = '{x1, x2, x3, x4};

    // x - max(x)
    max_normalize max_normalize_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_vec  (in_vec),
        .out_vec (norm_vec)
    );

    // e^(x - max) and its sum
    exp_bank exp_bank_a (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_vec  (norm_vec),
        .out_vec (exp_vec),
        .sum     (sum_a)
    );

    // (x - max) - ln(sum)
    log_normalize log_normalize_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .norm_vec (norm_vec),
        .sum_vec  (exp_vec),
        .sum      (sum_a),
        .out_vec  (log_vec)
    );

    // final probabilities, this sum is not needed
    exp_bank exp_bank_b (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_vec  (log_vec),
        .out_vec (res_vec),
        .sum     ()
    );

    assign busy = (state == BUSY);
    assign done = res_vec.valid;

    assign y1 = res_vec.lanes[0];
    assign y2 = res_vec.lanes[1];
    assign y3 = res_vec.lanes[2];
    assign y4 = res_vec.lanes[3];

endmodule

/* sim/tb_clk_gen.sv */
// tb_clk_gen: free-running testbench clock and a synchronous active-low reset pulse
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // reset held over the first rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* sim/tb_softmax.sv */
// tb_softmax: random and directed softmax vectors checked against a real-valued model
`timescale 1ns/1ps
`include "softmax_macros.svh"

module tb_softmax;
    import fixed_pkg::*;

    localparam int  N_RANDOM        = 200;
    localparam int  N_DIRECTED      = 6;
    localparam int  N_TESTS         = N_RANDOM + N_DIRECTED;
    localparam int  RESET_CYCLES    = 16;
    localparam int  WATCHDOG_CYCLES = N_TESTS * 10 + 100;
    localparam real SCALE           = real'(1 << `SOFTMAX_FRAC);
    // per-lane and summed tolerance against the exact softmax
    localparam real PROB_TOL        = 0.02;
    localparam real SUM_TOL         = 0.04;
    localparam fx_t FX_ONE          = fx_t'(1 << `SOFTMAX_FRAC);

    logic        clk;
    logic        rst_n;
    logic        start;
    fx_t         x1;
    fx_t         x2;
    fx_t         x3;
    fx_t         x4;
    fx_t         y1;
    fx_t         y2;
    fx_t         y3;
    fx_t         y4;
    logic        busy;
    logic        done;
    fx_t         y_out [`SOFTMAX_LANES];
    // current item, model result and last y seen at done
    fx_t         cur_x [`SOFTMAX_LANES];
    fx_t         want_y [`SOFTMAX_LANES];
    fx_t         held_y [`SOFTMAX_LANES];
    logic [15:0] lfsr_state;

    tb_clk_gen #(.PERIOD_NS(20), .RESET_CYCLES(RESET_CYCLES)) tb_clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    softmax_top softmax_top_i (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .x1    (x1),
        .x2    (x2),
        .x3    (x3),
        .x4    (x4),
        .y1    (y1),
        .y2    (y2),
        .y3    (y3),
        .y4    (y4),
        .busy  (busy),
        .done  (done)
    );

    assign y_out[0] = y1;
    assign y_out[1] = y2;
    assign y_out[2] = y3;
    assign y_out[3] = y4;

    // 16-bit fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // 20 bits sign-extended, range [-8, 8)
    task automatic random_fx(output fx_t v);
        logic [31:0] bits;
        take_bits(20, bits);
        v = {{(`SOFTMAX_WIDTH - 20){bits[19]}}, bits[19:0]};
    endtask

    function automatic real fx_to_real(input fx_t v);
        return $itor(v) / SCALE;
    endfunction

    function automatic fx_t real_to_fx(input real r);
        return fx_t'($rtoi($floor(r * SCALE + 0.5)));
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_prob(input string name, input fixed_pkg::fx_t got,
                              input fixed_pkg::fx_t expected);
        real diff;
        diff = fx_to_real(got) - fx_to_real(expected);
        if ($isunknown(got) || diff > PROB_TOL || diff < -PROB_TOL) begin
            report_failure($sformatf("mismatch %s: got %h expected %h", name, got, expected));
        end
    endtask

    task automatic check_sum(input fixed_pkg::fx_t got);
        real diff;
        diff = fx_to_real(got) - 1.0;
        if ($isunknown(got) || diff > SUM_TOL || diff < -SUM_TOL) begin
            report_failure($sformatf("mismatch y_sum: got %h expected %h", got, FX_ONE));
        end
    endtask

    // exact compare, for reset values and held outputs
    task automatic check_word(input string name, input fixed_pkg::fx_t got,
                              input fixed_pkg::fx_t expected);
        if (got !== expected) begin
            report_failure($sformatf("mismatch %s: got %h expected %h", name, got, expected));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            report_failure($sformatf("mismatch %s: got %h expected %h", name, got, expected));
        end
    endtask

    task automatic check_held();
        for (int i = 0; i < `SOFTMAX_LANES; i++) begin
            check_word($sformatf("y%0d", i + 1), y_out[i], held_y[i]);
        end
    endtask

    // exact softmax of cur_x in reals, max subtracted first
    task automatic compute_reference();
        real m;
        real s;
        real e [`SOFTMAX_LANES];
        m = fx_to_real(cur_x[0]);
        for (int i = 1; i < `SOFTMAX_LANES; i++) begin
            if (fx_to_real(cur_x[i]) > m) begin
                m = fx_to_real(cur_x[i]);
            end
        end
        s = 0.0;
        for (int i = 0; i < `SOFTMAX_LANES; i++) begin
            e[i] = $exp(fx_to_real(cur_x[i]) - m);
            s = s + e[i];
        end
        for (int i = 0; i < `SOFTMAX_LANES; i++) begin
            want_y[i] = real_to_fx(e[i] / s);
        end
    endtask

    // called on a falling edge, returns on the falling edge after done drops
    // inject puts a second start on a busy cycle 1..3 with other inputs
    task automatic run_item(input bit inject, input int inject_cycle);
        fx_t sum_y;
        compute_reference();
        start = 1'b1;
        x1 = cur_x[0];
        x2 = cur_x[1];
        x3 = cur_x[2];
        x4 = cur_x[3];
        for (int c = 1; c <= 5; c++) begin
            @(negedge clk);
            // done only in the cycle after the fourth edge, busy until then
            check_flag("done", done, c == 4);
            check_flag("busy", busy, c < 4);
            if (c == 4) begin
                sum_y = '0;
                for (int i = 0; i < `SOFTMAX_LANES; i++) begin
                    check_prob($sformatf("y%0d", i + 1), y_out[i], want_y[i]);
                    sum_y = sum_y + y_out[i];
                    held_y[i] = y_out[i];
                end
                check_sum(sum_y);
            end else begin
                check_held();
            end
            if (inject && c == inject_cycle) begin
                start = 1'b1;
                random_fx(x1);
                random_fx(x2);
                random_fx(x3);
                random_fx(x4);
            end else begin
                start = 1'b0;
            end
        end
    endtask

    // quiet cycles, outputs must not move
    task automatic idle_gap(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_flag("done", done, 1'b0);
            check_flag("busy", busy, 1'b0);
            check_held();
        end
    endtask

    initial begin
        repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge clk);
        report_failure("watchdog timeout, the tests did not finish in time");
    end

    initial begin
        logic [31:0] bits;
        fx_t         v;
        start = 1'b0;
        x1 = '0;
        x2 = '0;
        x3 = '0;
        x4 = '0;
        lfsr_state = 16'd77;
        @(posedge rst_n);

        // reset state
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        for (int i = 0; i < `SOFTMAX_LANES; i++) begin
            held_y[i] = '0;
        end
        check_held();

        // random vectors, some with a start while busy
        for (int n = 0; n < N_RANDOM; n++) begin
            for (int i = 0; i < `SOFTMAX_LANES; i++) begin
                random_fx(cur_x[i]);
            end
            take_bits(3, bits);
            run_item(bits[2], int'(bits[1:0]) % 3 + 1);
            take_bits(2, bits);
            idle_gap(int'(bits[1:0]));
        end

        // equal lanes, a fixed value then a random one
        for (int n = 0; n < 2; n++) begin
            random_fx(v);
            for (int i = 0; i < `SOFTMAX_LANES; i++) begin
                cur_x[i] = (n == 0) ? real_to_fx(1.5) : v;
            end
            run_item(n == 1, 2);
            for (int i = 0; i < `SOFTMAX_LANES; i++) begin
                check_prob($sformatf("y%0d equal", i + 1), y_out[i], real_to_fx(0.25));
            end
        end

        // one lane 8 above the rest, in each position
        for (int k = 0; k < `SOFTMAX_LANES; k++) begin
            for (int i = 0; i < `SOFTMAX_LANES; i++) begin
                cur_x[i] = (i == k) ? real_to_fx(4.0) : real_to_fx(-4.0);
            end
            run_item(1'b1, k % 3 + 1);
            check_prob($sformatf("y%0d peak", k + 1), y_out[k], FX_ONE);
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

/* compile.f */
+incdir+rtl
rtl/fixed_pkg.sv
rtl/softmax_pkg.sv
rtl/lane_vec_if.sv
rtl/exp_unit.sv
rtl/ln_unit.sv
rtl/max_normalize.sv
rtl/exp_bank.sv
rtl/log_normalize.sv
rtl/softmax_top.sv
sim/tb_clk_gen.sv
sim/tb_softmax.sv

/* run.sh */
#!/bin/sh
# build the softmax testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_softmax -o tb_softmax
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_softmax 2>&1)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
